// File: design/axi_pkg.sv
/* AXI4 encodings and widths */
package axi_pkg;

    // bus widths
    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int id_w   = 4;
    localparam int len_w  = 8;

    // burst types
    localparam logic [1:0] burst_incr = 2'b01;

    // response codes
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    // 4-byte beats
    localparam logic [2:0] size_word = 3'd2;

    // fixed ids, one per direction
    localparam logic [id_w-1:0] rd_id = 4'd0;
    localparam logic [id_w-1:0] wr_id = 4'd1;

    // attribute field widths
    localparam int cache_w = 4;
    localparam int prot_w  = 3;

endpackage

// File: design/l2_pkg.sv
/* L2 line geometry */
package l2_pkg;

    localparam int line_words = 4;
    localparam int line_bytes = line_words * (axi_pkg::data_w / 8); // 16
    localparam int beat_cnt_w = $clog2(line_words);

    // event counter width
    localparam int cnt_w = 16;

    // one bus word and its byte enables
    typedef logic [axi_pkg::data_w-1:0]   word_t;
    typedef logic [axi_pkg::data_w/8-1:0] strb_t;

    // whole line, word 0 in the low bits
    typedef word_t [line_words-1:0] line_t;
    typedef strb_t [line_words-1:0] line_strb_t;

endpackage

// File: design/axi_bridge.sv
/* AXI read and write channel control */
`timescale 1ns/100ps

module axi_bridge
    import axi_pkg::*;
(
    input  logic              clk,
    input  logic              rstn,
    // cache side
    input  logic              rd_req,
    input  logic [addr_w-1:0] rd_addr,
    output logic              rd_busy,
    output logic              rd_done,
    input  logic              wb_req,
    input  logic [addr_w-1:0] wb_addr,
    output logic              wb_busy,
    output logic              wb_done,
    output logic              wb_err,
    // AXI handshakes
    output logic [addr_w-1:0] araddr,
    output logic              arvalid,
    input  logic              arready,
    input  logic              rvalid,
    input  logic              rlast,
    output logic              rready,
    output logic [addr_w-1:0] awaddr,
    output logic              awvalid,
    input  logic              awready,
    output logic              wvalid,
    input  logic              wready,
    output logic              wlast,
    input  logic              bvalid,
    input  logic [1:0]        bresp,
    output logic              bready,
    // datapath control
    input  logic              wb_last,    // serializer is on its final word
    output logic              line_start,
    output logic              beat_push,
    output logic              wb_load,
    output logic              beat_pop
);

    typedef enum logic [1:0] {
        r_idle,
        r_addr,
        r_data
    } rd_state_t;

    typedef enum logic [1:0] {
        w_idle,
        w_addr,
        w_data,
        w_resp
    } wr_state_t;

    rd_state_t r_state;
    wr_state_t w_state;

    logic rd_accept;
    logic wb_accept;
    logic w_beat;

    // read channel

    // busy also covers the done cycle so a new request waits for it
    assign rd_busy    = (r_state != r_idle) | rd_done;
    assign rd_accept  = rd_req & ~rd_busy;
    assign line_start = rd_accept;

    assign arvalid   = (r_state == r_addr);
    assign rready    = (r_state == r_data);
    assign beat_push = rvalid & rready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            r_state <= r_idle;
            rd_done <= 1'b0;
        end else begin
            rd_done <= beat_push & rlast;   // one cycle after the last beat
            case (r_state)
                r_idle: if (rd_accept) r_state <= r_addr;
                r_addr: if (arready) r_state <= r_data;
                r_data: if (beat_push && rlast) r_state <= r_idle;
                default: r_state <= r_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) araddr <= rd_addr;    // held stable through AR
    end

    // write channel
    assign wb_busy   = (w_state != w_idle) | wb_done;
    assign wb_accept = wb_req & ~wb_busy;
    assign wb_load   = wb_accept;

    assign awvalid = (w_state == w_addr);
    assign wvalid  = (w_state == w_data);
    assign wlast   = wvalid & wb_last;
    assign bready  = (w_state == w_resp);

    assign w_beat   = wvalid & wready;
    assign beat_pop = w_beat;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            w_state <= w_idle;
            wb_done <= 1'b0;
        end else begin
            wb_done <= bvalid & bready;
            case (w_state)
                w_idle: if (wb_accept) w_state <= w_addr;
                w_addr: if (awready) w_state <= w_data;
                w_data: if (w_beat && wb_last) w_state <= w_resp;
                w_resp: if (bvalid) w_state <= w_idle;
                default: w_state <= w_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wb_accept) awaddr <= wb_addr;
        if (bvalid && bready) begin
            wb_err <= (bresp != resp_okay); // read by the host with wb_done
        end
    end

endmodule

// File: design/refill_assembler.sv
/* refill line collector */
`timescale 1ns/100ps

module refill_assembler
    import axi_pkg::*;
    import l2_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       line_start,
    input  logic       beat_push,
    input  word_t      rdata,
    input  logic [1:0] rresp,
    output line_t      line,
    output logic       err
);

    logic [beat_cnt_w-1:0] beat_idx;
    line_t                 line_q;

    // beat index and sticky error
    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_idx <= '0;
            err      <= 1'b0;
        end else if (line_start) begin
            beat_idx <= '0;
            err      <= 1'b0;
        end else if (beat_push) begin
            beat_idx <= beat_idx + 1'b1;   // wraps after the last word
            if (rresp != resp_okay) begin
                err <= 1'b1;
            end
        end
    end

    // word slots
    always_ff @(posedge clk) begin
        if (beat_push) begin
            line_q[beat_idx] <= rdata;
        end
    end

    assign line = line_q;

endmodule

// File: design/wb_serializer.sv
/* writeback beat serializer */
`timescale 1ns/100ps

module wb_serializer
    import l2_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       wb_load,
    input  line_t      wb_line,
    input  line_strb_t wb_strb,
    input  logic       beat_pop,
    output word_t      wdata,
    output strb_t      wstrb,
    output logic       last
);

    localparam logic [beat_cnt_w-1:0] last_idx = beat_cnt_w'(line_words - 1);

    logic [beat_cnt_w-1:0] beat_idx;
    line_t                 line_q;
    line_strb_t            strb_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            beat_idx <= '0;
        end else if (wb_load) begin
            beat_idx <= '0;
        end else if (beat_pop) begin
            beat_idx <= beat_idx + 1'b1;
        end
    end

    // line payload, no reset
    always_ff @(posedge clk) begin
        if (wb_load) begin
            line_q <= wb_line;
            strb_q <= wb_strb;
        end
    end

    assign wdata = line_q[beat_idx];
    assign wstrb = strb_q[beat_idx];   // per-word byte enables
    assign last  = (beat_idx == last_idx);

endmodule

// File: design/axi_port_regs.sv
/* port config and event counters */
`timescale 1ns/100ps

module axi_port_regs
    import axi_pkg::*;
    import l2_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    input  logic               cfg_we,
    input  logic [1:0]         cfg_addr,
    input  logic [31:0]        cfg_wdata,
    output logic [31:0]        cfg_rdata,
    input  logic               rd_done,
    input  logic               rd_err,
    input  logic               wb_done,
    input  logic               wb_err,
    output logic [cache_w-1:0] arcache,
    output logic [cache_w-1:0] awcache,
    output logic [prot_w-1:0]  axprot
);

    localparam int attr_w = 2 * cache_w + prot_w;

    logic [attr_w-1:0] attr_q;
    logic [cnt_w-1:0]  cnt_q [1:3];   // refills, writebacks, errors
    logic [1:0]        cnt_inc [1:3];

    // register 0: attributes
    always_ff @(posedge clk) begin
        if (!rstn) begin
            attr_q <= '0;
        end else if (cfg_we && cfg_addr == 2'd0) begin
            attr_q <= cfg_wdata[attr_w-1:0];
        end
    end

    assign arcache = attr_q[cache_w-1:0];
    assign awcache = attr_q[2*cache_w-1:cache_w];
    assign axprot  = attr_q[attr_w-1:2*cache_w];

    // both channels can report an error in the same cycle
    assign cnt_inc[1] = {1'b0, rd_done};
    assign cnt_inc[2] = {1'b0, wb_done};
    assign cnt_inc[3] = {1'b0, rd_done & rd_err} + {1'b0, wb_done & wb_err};

    always_ff @(posedge clk) begin
        for (int i = 1; i <= 3; i++) begin
            if (!rstn) begin
                cnt_q[i] <= '0;
            end else if (cfg_we && cfg_addr == 2'(i)) begin
                cnt_q[i] <= '0;           // any write clears
            end else begin
                cnt_q[i] <= cnt_q[i] + cnt_w'(cnt_inc[i]);
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            2'd0: cfg_rdata = 32'(attr_q);
            2'd1: cfg_rdata = 32'(cnt_q[1]);
            2'd2: cfg_rdata = 32'(cnt_q[2]);
            default: cfg_rdata = 32'(cnt_q[3]);
        endcase
    end

endmodule

// File: design/l2_mem_port.sv
/* L2 AXI4 memory port */
`timescale 1ns/100ps

module l2_mem_port
    import axi_pkg::*;
    import l2_pkg::*;
(
    input  logic               clk,
    input  logic               rstn,
    // refill
    input  logic               rd_req,
    input  logic [addr_w-1:0]  rd_addr,
    output logic               rd_busy,
    output logic               rd_done,
    output line_t              rd_line,
    output logic               rd_err,
    // writeback
    input  logic               wb_req,
    input  logic [addr_w-1:0]  wb_addr,
    input  line_t              wb_line,
    input  line_strb_t         wb_strb,
    output logic               wb_busy,
    output logic               wb_done,
    output logic               wb_err,
    // config
    input  logic               cfg_we,
    input  logic [1:0]         cfg_addr,
    input  logic [31:0]        cfg_wdata,
    output logic [31:0]        cfg_rdata,
    // AR
    output logic [id_w-1:0]    arid,
    output logic [addr_w-1:0]  araddr,
    output logic [len_w-1:0]   arlen,
    output logic [2:0]         arsize,
    output logic [1:0]         arburst,
    output logic               arlock,
    output logic [cache_w-1:0] arcache,
    output logic [prot_w-1:0]  arprot,
    output logic               arvalid,
    input  logic               arready,
    // R
    input  word_t              rdata,
    input  logic [1:0]         rresp,
    input  logic               rlast,
    input  logic               rvalid,
    output logic               rready,
    // AW
    output logic [id_w-1:0]    awid,
    output logic [addr_w-1:0]  awaddr,
    output logic [len_w-1:0]   awlen,
    output logic [2:0]         awsize,
    output logic [1:0]         awburst,
    output logic               awlock,
    output logic [cache_w-1:0] awcache,
    output logic [prot_w-1:0]  awprot,
    output logic               awvalid,
    input  logic               awready,
    // W
    output word_t              wdata,
    output strb_t              wstrb,
    output logic               wlast,
    output logic               wvalid,
    input  logic               wready,
    // B
    input  logic [1:0]         bresp,
    input  logic               bvalid,
    output logic               bready
);

    logic                line_start;
    logic                beat_push;
    logic                wb_load;
    logic                beat_pop;
    logic                wb_last;
    logic [prot_w-1:0]   axprot;

    // fixed burst shape, one full line per burst
    assign arid    = rd_id;
    assign awid    = wr_id;
    assign arlen   = len_w'(line_words - 1);
    assign awlen   = len_w'(line_words - 1);
    assign arsize  = size_word;
    assign awsize  = size_word;
    assign arburst = burst_incr;
    assign awburst = burst_incr;
    assign arlock  = 1'b0;   // no exclusive access
    assign awlock  = 1'b0;
    assign arprot  = axprot;
    assign awprot  = axprot;

    axi_bridge u_bridge (
        .clk        (clk),
        .rstn       (rstn),
        .rd_req     (rd_req),
        .rd_addr    (rd_addr),
        .rd_busy    (rd_busy),
        .rd_done    (rd_done),
        .wb_req     (wb_req),
        .wb_addr    (wb_addr),
        .wb_busy    (wb_busy),
        .wb_done    (wb_done),
        .wb_err     (wb_err),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rvalid     (rvalid),
        .rlast      (rlast),
        .rready     (rready),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wvalid     (wvalid),
        .wready     (wready),
        .wlast      (wlast),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready),
        .wb_last    (wb_last),
        .line_start (line_start),
        .beat_push  (beat_push),
        .wb_load    (wb_load),
        .beat_pop   (beat_pop)
    );

    refill_assembler u_assembler (
        .clk        (clk),
        .rstn       (rstn),
        .line_start (line_start),
        .beat_push  (beat_push),
        .rdata      (rdata),
        .rresp      (rresp),
        .line       (rd_line),
        .err        (rd_err)
    );

    wb_serializer u_serializer (
        .clk      (clk),
        .rstn     (rstn),
        .wb_load  (wb_load),
        .wb_line  (wb_line),
        .wb_strb  (wb_strb),
        .beat_pop (beat_pop),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .last     (wb_last)
    );

    axi_port_regs u_regs (
        .clk       (clk),
        .rstn      (rstn),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .rd_done   (rd_done),
        .rd_err    (rd_err),
        .wb_done   (wb_done),
        .wb_err    (wb_err),
        .arcache   (arcache),
        .awcache   (awcache),
        .axprot    (axprot)
    );

endmodule

// File: bench/axi_mem_model.sv
/* AXI slave memory model */
`timescale 1ns/100ps

module axi_mem_model
    import axi_pkg::*;
#(
    parameter int err_lo  = 224,   // first word of the SLVERR window
    parameter int err_hi  = 255,
    parameter int max_gap = 3      // longest run of stall cycles
)(
    input  logic              clk,
    input  logic              rstn,
    input  logic [addr_w-1:0] araddr,
    input  logic [7:0]        arlen,
    input  logic              arvalid,
    output logic              arready,
    output logic [data_w-1:0] rdata,
    output logic [1:0]        rresp,
    output logic              rlast,
    output logic              rvalid,
    input  logic              rready,
    input  logic [addr_w-1:0] awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [data_w-1:0] wdata,
    input  logic [3:0]        wstrb,
    input  logic              wlast,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready
);

    logic [data_w-1:0] mem [256];
    logic [31:0]       lfsr;
    logic [7:0]        rd_ptr;
    logic [7:0]        rd_left;   // beats after the current one
    logic [7:0]        wr_ptr;
    logic              rd_active;
    logic              wr_active;
    logic              b_pend;
    logic              wr_bad;
    logic [1:0]        ar_wait;
    logic [1:0]        r_wait;
    logic [1:0]        aw_wait;
    logic [1:0]        w_wait;
    logic [1:0]        b_wait;

    function automatic logic [data_w-1:0] fill_word(logic [7:0] a);
        return {a, ~a, a * 8'd7 + 8'd1, a ^ 8'ha5};
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic in_window(logic [7:0] w);
        return (w >= err_lo) && (w <= err_hi);
    endfunction

    // one random bit, forced high after max_gap misses
    task automatic pick(inout logic [1:0] wait_cnt, output logic go);
        lfsr     = lfsr_next(lfsr);
        go       = lfsr[0] || (wait_cnt == max_gap);
        wait_cnt = go ? 2'd0 : wait_cnt + 2'd1;
    endtask

    initial begin
        arready = 1'b0;
        rdata   = '0;
        rresp   = resp_okay;
        rlast   = 1'b0;
        rvalid  = 1'b0;
        awready = 1'b0;
        wready  = 1'b0;
        bresp   = resp_okay;
        bvalid  = 1'b0;
    end

    always @(posedge clk) begin
        logic go;
        if (!rstn) begin
            lfsr    = 32'hcb32;
            ar_wait = '0;
            r_wait  = '0;
            aw_wait = '0;
            w_wait  = '0;
            b_wait  = '0;
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            rlast     <= 1'b0;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            b_pend    <= 1'b0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= fill_word(8'(i));
            end
        end else begin
            // read address
            if (arvalid && arready) begin
                rd_active <= 1'b1;
                rd_ptr    <= araddr[9:2];
                rd_left   <= arlen;
                arready   <= 1'b0;
            end else begin
                pick(ar_wait, go);
                arready <= go && !rd_active;
            end
            // read data, one gap cycle at least between beats
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_ptr  <= rd_ptr + 8'd1;
                rd_left <= rd_left - 8'd1;
                if (rlast) begin
                    rd_active <= 1'b0;
                end
            end else if (rd_active && !rvalid) begin
                pick(r_wait, go);
                if (go) begin
                    rvalid <= 1'b1;
                    rdata  <= mem[rd_ptr];
                    rresp  <= in_window(rd_ptr) ? resp_slverr : resp_okay;
                    rlast  <= (rd_left == 8'd0);
                end
            end
            // write address
            if (awvalid && awready) begin
                wr_active <= 1'b1;
                wr_ptr    <= awaddr[9:2];
                wr_bad    <= 1'b0;
                awready   <= 1'b0;
            end else begin
                pick(aw_wait, go);
                awready <= go && !wr_active;
            end
            // write data, error window is left untouched
            if (wvalid && wready) begin
                if (in_window(wr_ptr)) begin
                    wr_bad <= 1'b1;
                end else begin
                    for (int b = 0; b < 4; b++) begin
                        if (wstrb[b]) mem[wr_ptr][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
                wr_ptr <= wr_ptr + 8'd1;
                if (wlast) begin
                    b_pend <= 1'b1;
                end
            end
            pick(w_wait, go);
            wready <= go && wr_active && !b_pend;
            // write response
            if (bvalid && bready) begin
                bvalid    <= 1'b0;
                b_pend    <= 1'b0;
                wr_active <= 1'b0;
            end else if (b_pend && !bvalid) begin
                pick(b_wait, go);
                if (go) begin
                    bvalid <= 1'b1;
                    bresp  <= wr_bad ? resp_slverr : resp_okay;
                end
            end
        end
    end

endmodule

// File: bench/tb_l2_mem_port.sv
/* L2 memory port testbench */
`timescale 1ns/100ps

module tb_l2_mem_port
    import axi_pkg::*;
    import l2_pkg::*;
();

    localparam int err_lo    = 224;   // words 224..255 answer SLVERR
    localparam int err_hi    = 255;
    localparam int max_gap   = 3;
    localparam int n_refill  = 10;
    localparam int n_wb_ops  = 8;
    localparam int n_pair    = 6;
    localparam int n_err_ops = 2;
    // worst-case cycles per burst with every channel stalled
    localparam int op_cycles  = (line_words + 3) * (max_gap + 2) + 8;
    localparam int n_ops      = n_refill + 2 * n_wb_ops + 2 * n_pair + 3 * n_err_ops;
    localparam int timeout_ns = (n_ops * op_cycles + 100) * 10;

    logic               clk;
    logic               rstn;
    logic               rd_req;
    logic [addr_w-1:0]  rd_addr;
    logic               rd_busy;
    logic               rd_done;
    line_t              rd_line;
    logic               rd_err;
    logic               wb_req;
    logic [addr_w-1:0]  wb_addr;
    line_t              wb_line;
    line_strb_t         wb_strb;
    logic               wb_busy;
    logic               wb_done;
    logic               wb_err;
    logic               cfg_we;
    logic [1:0]         cfg_addr;
    logic [31:0]        cfg_wdata;
    logic [31:0]        cfg_rdata;
    logic [id_w-1:0]    arid;
    logic [addr_w-1:0]  araddr;
    logic [len_w-1:0]   arlen;
    logic [2:0]         arsize;
    logic [1:0]         arburst;
    logic               arlock;
    logic [cache_w-1:0] arcache;
    logic [prot_w-1:0]  arprot;
    logic               arvalid;
    logic               arready;
    word_t              rdata;
    logic [1:0]         rresp;
    logic               rlast;
    logic               rvalid;
    logic               rready;
    logic [id_w-1:0]    awid;
    logic [addr_w-1:0]  awaddr;
    logic [len_w-1:0]   awlen;
    logic [2:0]         awsize;
    logic [1:0]         awburst;
    logic               awlock;
    logic [cache_w-1:0] awcache;
    logic [prot_w-1:0]  awprot;
    logic               awvalid;
    logic               awready;
    word_t              wdata;
    strb_t              wstrb;
    logic               wlast;
    logic               wvalid;
    logic               wready;
    logic [1:0]         bresp;
    logic               bvalid;
    logic               bready;

    word_t             shadow [256];
    logic [31:0]       lfsr;
    logic [10:0]       attr;          // attribute value last written
    int                errors;
    int                n_rd;
    int                n_wb;
    int                n_err;
    int                w_beat;
    line_t             rd_exp_line [$];
    logic              rd_exp_err [$];
    logic              wb_exp_err [$];
    logic [addr_w-1:0] ar_exp [$];
    logic [addr_w-1:0] aw_exp [$];

    l2_mem_port dut0 (.*);

    axi_mem_model #(.err_lo(err_lo), .err_hi(err_hi), .max_gap(max_gap)) mem0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t fill_word(logic [7:0] a);
        return {a, ~a, a * 8'd7 + 8'd1, a ^ 8'ha5};
    endfunction

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic logic in_window(logic [addr_w-1:0] a);
        return (a[9:2] >= err_lo) && (a[9:2] <= err_hi);
    endfunction

    // reference line from the shadow memory
    function automatic line_t expected_line(logic [addr_w-1:0] a);
        line_t l;
        for (int i = 0; i < line_words; i++) begin
            l[i] = shadow[a[9:2] + i];
        end
        return l;
    endfunction

    function automatic word_t merge_word(word_t old, word_t nw, strb_t s);
        word_t r;
        r = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) r[8*b +: 8] = nw[8*b +: 8];
        end
        return r;
    endfunction

    task automatic check_value(input string what, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // random line outside the error window
    task automatic rand_line(output logic [addr_w-1:0] a);
        logic [31:0] v;
        rand_bits(6, v);
        a = addr_w'((v % (err_lo / line_words)) * line_bytes);
    endtask

    task automatic rand_payload(output line_t l, output line_strb_t s);
        logic [31:0] v;
        for (int i = 0; i < line_words; i++) begin
            rand_bits(32, v);
            l[i] = v;
            rand_bits(4, v);
            s[i] = v[3:0];
        end
    endtask

    task automatic wait_idle();
        while (rd_busy || wb_busy) @(negedge clk);
    endtask

    task automatic queue_refill(input logic [addr_w-1:0] a);
        rd_exp_line.push_back(expected_line(a));
        rd_exp_err.push_back(in_window(a));
        ar_exp.push_back(a);
        n_rd++;
        if (in_window(a)) n_err++;
        rd_req  = 1'b1;
        rd_addr = a;
    endtask

    task automatic queue_writeback(input logic [addr_w-1:0] a, input line_t l,
                                   input line_strb_t s);
        wb_exp_err.push_back(in_window(a));
        aw_exp.push_back(a);
        n_wb++;
        if (in_window(a)) begin
            n_err++;
        end else begin
            for (int i = 0; i < line_words; i++) begin
                shadow[a[9:2] + i] = merge_word(shadow[a[9:2] + i], l[i], s[i]);
            end
        end
        wb_req  = 1'b1;
        wb_addr = a;
        wb_line = l;
        wb_strb = s;
    endtask

    task automatic release_reqs();
        @(negedge clk);
        rd_req = 1'b0;
        wb_req = 1'b0;
    endtask

    // returns on a falling edge once every completion was compared
    task automatic drain();
        while (rd_exp_err.size() != 0 || wb_exp_err.size() != 0) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic write_reg(input logic [1:0] a, input logic [31:0] d);
        cfg_we    = 1'b1;
        cfg_addr  = a;
        cfg_wdata = d;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic check_reg(input logic [1:0] a, input int exp, input string what);
        cfg_addr = a;
        #1;
        check_value(what, cfg_rdata, exp);
        @(negedge clk);
    endtask

    // compare each completion with the reference
    always @(negedge clk) begin
        line_t exp_line;
        logic  exp_err;
        if (rstn && rd_done) begin
            if (rd_exp_err.size() == 0) begin
                errors++;
                $display("error at %0t ns: rd_done pulsed with no refill outstanding", $time);
            end else begin
                exp_line = rd_exp_line.pop_front();
                exp_err  = rd_exp_err.pop_front();
                check_value("rd_err at rd_done", rd_err, exp_err);
                if (!exp_err) check_value("rd_line at rd_done", rd_line, exp_line);
            end
        end
        if (rstn && wb_done) begin
            if (wb_exp_err.size() == 0) begin
                errors++;
                $display("error at %0t ns: wb_done pulsed with no writeback outstanding", $time);
            end else begin
                check_value("wb_err at wb_done", wb_err, wb_exp_err.pop_front());
            end
        end
    end

    // AXI address and W beat monitor
    always @(negedge clk) begin
        if (rstn && arvalid && arready) begin
            check_value("araddr", araddr, ar_exp.pop_front());
            check_value("arlen", arlen, line_words - 1);
            check_value("arsize", arsize, 3'd2);
            check_value("arburst", arburst, 2'b01);
            check_value("arid", arid, 0);
            check_value("arlock", arlock, 1'b0);
            check_value("arcache", arcache, attr[3:0]);
            check_value("arprot", arprot, attr[10:8]);
        end
        if (rstn && awvalid && awready) begin
            check_value("awaddr", awaddr, aw_exp.pop_front());
            check_value("awlen", awlen, line_words - 1);
            check_value("awsize", awsize, 3'd2);
            check_value("awburst", awburst, 2'b01);
            check_value("awid", awid, 1);
            check_value("awlock", awlock, 1'b0);
            check_value("awcache", awcache, attr[7:4]);
            check_value("awprot", awprot, attr[10:8]);
        end
        if (rstn && wvalid && wready) begin
            check_value("wlast", wlast, w_beat == line_words - 1);
            w_beat = (w_beat == line_words - 1) ? 0 : w_beat + 1;
        end
    end

    initial begin
        #(timeout_ns);
        $display("timeout: the run did not finish within %0d ns, a transfer hung", timeout_ns);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [addr_w-1:0] a;
        logic [addr_w-1:0] b;
        logic [31:0]       v;
        line_t             l;
        line_strb_t        s;
        rstn      = 1'b0;
        rd_req    = 1'b0;
        rd_addr   = '0;
        wb_req    = 1'b0;
        wb_addr   = '0;
        wb_line   = '0;
        wb_strb   = '0;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        lfsr      = 32'hcb32;
        attr      = '0;
        errors    = 0;
        n_rd      = 0;
        n_wb      = 0;
        n_err     = 0;
        w_beat    = 0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = fill_word(8'(i));
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // idle after reset
        check_value("idle outputs after reset",
                    {arvalid, rready, awvalid, wvalid, bready, rd_done, wb_done,
                     rd_busy, wb_busy}, '0);
        check_reg(2'd0, 0, "attributes after reset");

        // attribute fields
        attr = 11'h5a7;
        write_reg(2'd0, 32'(attr));
        check_value("arcache", arcache, attr[3:0]);
        check_value("awcache", awcache, attr[7:4]);
        check_value("arprot", arprot, attr[10:8]);
        check_value("awprot", awprot, attr[10:8]);

        repeat (n_refill) begin
            rand_line(a);
            wait_idle();
            queue_refill(a);
            release_reqs();
        end
        drain();

        // writeback, then read the merged line back
        repeat (n_wb_ops) begin
            rand_line(a);
            rand_payload(l, s);
            wait_idle();
            queue_writeback(a, l, s);
            release_reqs();
            wait_idle();
            queue_refill(a);
            release_reqs();
        end
        drain();

        // both channels at once on different lines
        repeat (n_pair) begin
            rand_line(a);
            rand_line(b);
            if (b == a) b = a ^ addr_w'(line_bytes);
            rand_payload(l, s);
            wait_idle();
            queue_refill(a);
            queue_writeback(b, l, s);
            release_reqs();
        end
        drain();

        // error window accesses and a clean refill after each
        repeat (n_err_ops) begin
            rand_bits(3, v);
            a = addr_w'(err_lo * 4 + v[2:0] * line_bytes);
            rand_payload(l, s);
            wait_idle();
            queue_refill(a);
            release_reqs();
            wait_idle();
            queue_writeback(a, l, s);
            release_reqs();
            rand_line(b);
            wait_idle();
            queue_refill(b);
            release_reqs();
        end
        drain();
        check_reg(2'd3, n_err, "error counter");

        check_reg(2'd1, n_rd, "refill counter");
        check_reg(2'd2, n_wb, "writeback counter");
        write_reg(2'd1, '0);
        write_reg(2'd2, '0);
        check_reg(2'd1, 0, "refill counter after clear");
        check_reg(2'd2, 0, "writeback counter after clear");

        $display("run complete: %0d refills, %0d writebacks, %0d errors", n_rd, n_wb, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: sources.f
design/axi_pkg.sv
design/l2_pkg.sv
design/axi_bridge.sv
design/refill_assembler.sv
design/wb_serializer.sv
design/axi_port_regs.sv
design/l2_mem_port.sv
bench/axi_mem_model.sv
bench/tb_l2_mem_port.sv

// File: Bender.yml
package:
  name: l2_mem_port

sources:
  # packages first, then the RTL bottom up
  - design/axi_pkg.sv
  - design/l2_pkg.sv
  - design/axi_bridge.sv
  - design/refill_assembler.sv
  - design/wb_serializer.sv
  - design/axi_port_regs.sv
  - design/l2_mem_port.sv
  - target: simulation
    files:
      - bench/axi_mem_model.sv
      - bench/tb_l2_mem_port.sv
